/* compile.f */
+incdir+hw
hw/cdcFifoPkg.sv
hw/cdcPtrIf.sv
hw/grayPtrCounter.sv
hw/ptrSyncChain.sv
hw/cdcFifo.sv
hw/cdcStreamBridge.sv
tests/cdcFifo_properties.sv
tests/tb_cdcStreamBridge.sv

/* hw/cdcFifo.sv */
// dual-clock FIFO core with memory, write and read pointer counters and pointer sync chains
`default_nettype none

`include "cdcFifo_consts.svh"

module cdcFifo
    import cdcFifoPkg::*;
(
    // write domain
    input  logic  w_clk,
    input  logic  rst,
    input  logic  dInAck,
    input  data_t dIn,
    output logic  dInReq,

    // read domain
    input  logic  r_clk,
    input  logic  dOutReq,
    output logic  dOutAck,
    output data_t dOut
);

    // storage, no reset on the payload
    data_t mem [`CDC_DEPTH];

    // accepted push and take
    logic writeEn;
    logic readEn;

    // write Gray pointer after launch and after the read-domain sync
    ptr_t wrGrayLaunch;
    ptr_t wrGraySync;

    // read Gray pointer after launch and after the write-domain sync
    ptr_t rdGrayLaunch;
    ptr_t rdGraySync;

    // one pointer bundle per clock domain
    cdcPtrIf wrPtr ();
    cdcPtrIf rdPtr ();

    // push only lands while not full
    assign writeEn = dInAck & dInReq;
    // take only lands while not empty
    assign readEn = dOutReq & dOutAck;

    // write counter in w_clk, match means full
    grayPtrCounter #(
        .SIDE (WRITE_SIDE)
    ) uWrCounter (
        .clk (w_clk),
        .rst (rst),
        .ptr (wrPtr)
    );

    // read counter in r_clk, match means empty
    grayPtrCounter #(
        .SIDE (READ_SIDE)
    ) uRdCounter (
        .clk (r_clk),
        .rst (rst),
        .ptr (rdPtr)
    );

    assign wrPtr.countEn = writeEn;
    assign rdPtr.countEn = readEn;

    // write pointer crossing: launch flop in w_clk, then synchronizer in r_clk
    ptrSyncChain #(
        .STAGES (1)
    ) uWrLaunch (
        .clk  (w_clk),
        .rst  (rst),
        .dIn  (wrPtr.grayPtr),
        .dOut (wrGrayLaunch)
    );

    ptrSyncChain #(
        .STAGES (`CDC_SYNC_STAGES)
    ) uWrToRdSync (
        .clk  (r_clk),
        .rst  (rst),
        .dIn  (wrGrayLaunch),
        .dOut (wrGraySync)
    );

    // read pointer crossing, mirror of the write side
    ptrSyncChain #(
        .STAGES (1)
    ) uRdLaunch (
        .clk  (r_clk),
        .rst  (rst),
        .dIn  (rdPtr.grayPtr),
        .dOut (rdGrayLaunch)
    );

    ptrSyncChain #(
        .STAGES (`CDC_SYNC_STAGES)
    ) uRdToWrSync (
        .clk  (w_clk),
        .rst  (rst),
        .dIn  (rdGrayLaunch),
        .dOut (rdGraySync)
    );

    // each counter compares against the other side's delayed pointer
    // the delay only makes full and empty pessimistic
    assign wrPtr.remotePtr = rdGraySync;
    assign rdPtr.remotePtr = wrGraySync;

    // memory write at the accepting w_clk edge
    always_ff @(posedge w_clk) begin
        if (writeEn) begin
            mem[wrPtr.binaryPtr] <= dIn;
        end
    end

    // head word only while a take happens, zero otherwise
    assign dOut = readEn ? mem[rdPtr.binaryPtr] : '0;

    // ready while not full, available while not empty
    assign dInReq  = ~wrPtr.ptrMatch;
    assign dOutAck = ~rdPtr.ptrMatch;

endmodule

`default_nettype wire

/* hw/cdcFifoPkg.sv */
// data, address and pointer types plus the pointer-side enum for the dual-clock FIFO
`default_nettype none

`include "cdcFifo_consts.svh"

package cdcFifoPkg;

    // one stored word
    typedef logic [`CDC_DATA_WIDTH-1:0] data_t;

    // memory address
    typedef logic [`CDC_ADDR_WIDTH-1:0] addr_t;

    // wrap-extended pointer, binary or Gray
    // msb toggles once per full pass over the memory
    typedef logic [`CDC_ADDR_WIDTH:0] ptr_t;

    // which side a pointer counter serves
    // write side matches on full, read side matches on empty
    typedef enum logic {
        WRITE_SIDE = 1'b0,
        READ_SIDE  = 1'b1
    } ptrSide_e;

endpackage

`default_nettype wire

/* hw/cdcFifo_consts.svh */
// width, depth, address width and synchronizer depth macros for the dual-clock FIFO
`ifndef CDC_FIFO_CONSTS_SVH
`define CDC_FIFO_CONSTS_SVH

// width of one stored word
`define CDC_DATA_WIDTH 8

// number of FIFO entries, a power of two
`define CDC_DEPTH 16

// memory address width, log2 of the depth
// pointers carry one extra wrap bit on top of this
`define CDC_ADDR_WIDTH 4

// flops in each destination-domain synchronizer
// the source-domain launch register comes on top of these
`define CDC_SYNC_STAGES 3

`endif

/* hw/cdcPtrIf.sv */
// pointer counter bundle of one clock domain, with counter and core modports
`default_nettype none

interface cdcPtrIf
    import cdcFifoPkg::*;
();

    // step request from the core, one per accepted push or take
    logic  countEn;
    // memory address, low bits of the binary pointer
    addr_t binaryPtr;
    // registered Gray image of the local pointer
    ptr_t  grayPtr;
    // Gray pointer of the other domain, already synchronized
    ptr_t  remotePtr;
    // full on the write side, empty on the read side
    logic  ptrMatch;

    // seen from the pointer counter
    modport counter (
        input  countEn,
        input  remotePtr,
        output binaryPtr,
        output grayPtr,
        output ptrMatch
    );

    // seen from the FIFO core
    modport core (
        output countEn,
        output remotePtr,
        input  binaryPtr,
        input  grayPtr,
        input  ptrMatch
    );

endinterface

`default_nettype wire

/* hw/cdcStreamBridge.sv */
// dual-clock stream bridge top level with plain level and strobe ports
`default_nettype none

module cdcStreamBridge
    import cdcFifoPkg::*;
(
    // write domain
    // dInReq high while the bridge can take a word
    // dInAck strobes a push in the same cycle
    input  logic  w_clk,
    input  logic  rst,
    input  logic  dInAck,
    input  data_t dIn,
    output logic  dInReq,

    // read domain
    // dOutAck high while a word is waiting
    // dOutReq strobes a take, dOut carries the word in that cycle
    input  logic  r_clk,
    input  logic  dOutReq,
    output logic  dOutAck,
    output data_t dOut
);

    // one synchronous rst, sampled in both domains
    // strobes against a low level are dropped by the core
    cdcFifo uFifo (
        .w_clk   (w_clk),
        .rst     (rst),
        .dInAck  (dInAck),
        .dIn     (dIn),
        .dInReq  (dInReq),
        .r_clk   (r_clk),
        .dOutReq (dOutReq),
        .dOutAck (dOutAck),
        .dOut    (dOut)
    );

endmodule

`default_nettype wire

/* hw/grayPtrCounter.sv */
// binary and Gray pointer counter with full or empty match against a remote pointer
`default_nettype none

`include "cdcFifo_consts.svh"

module grayPtrCounter
    import cdcFifoPkg::*;
#(
    // write side flags full, read side flags empty
    parameter ptrSide_e SIDE = WRITE_SIDE
) (
    input  logic clk,
    input  logic rst,
    cdcPtrIf.counter ptr
);

    // top index of the wrap-extended pointer
    localparam int TOP = `CDC_ADDR_WIDTH;

    // wrap-extended binary count
    ptr_t binQ;
    // registered Gray image, the only value that crosses domains
    ptr_t grayQ;
    // next values while stepping
    ptr_t binNext;
    ptr_t grayNext;
    // remote pointer as it reads when the FIFO is full
    ptr_t fullImage;
    logic fullMatch;
    logic emptyMatch;

    // one step ahead of the current count
    assign binNext = binQ + ptr_t'(1);

    // binary to Gray, adjacent counts differ in one bit
    assign grayNext = binNext ^ (binNext >> 1);

    // both images step together, one cycle after countEn
    always_ff @(posedge clk) begin
        if (rst) begin
            binQ  <= '0;
            grayQ <= '0;
        end else if (ptr.countEn) begin
            binQ  <= binNext;
            grayQ <= grayNext;
        end
    end

    // full: writer is one lap ahead of the reader
    // in Gray terms the two top bits differ and the rest match
    assign fullImage = {~ptr.remotePtr[TOP:TOP-1], ptr.remotePtr[TOP-2:0]};
    assign fullMatch = (grayQ == fullImage);

    // empty: both pointers on the same count
    assign emptyMatch = (grayQ == ptr.remotePtr);

    // the side picks the match rule
    assign ptr.ptrMatch = (SIDE == WRITE_SIDE) ? fullMatch : emptyMatch;

    // memory address drops the wrap bit
    assign ptr.binaryPtr = binQ[TOP-1:0];

    // Gray pointer goes out registered, never from logic
    assign ptr.grayPtr = grayQ;

endmodule

`default_nettype wire

/* hw/ptrSyncChain.sv */
// reset-to-zero register chain for Gray pointers, as launch register or synchronizer
`default_nettype none

module ptrSyncChain
    import cdcFifoPkg::*;
#(
    // number of register stages, 1 or more
    parameter int STAGES = 2
) (
    input  logic clk,
    input  logic rst,
    input  ptr_t dIn,
    output ptr_t dOut
);

    // stage 0 samples dIn, last stage drives dOut
    ptr_t stageQ [STAGES];

    // whole pointer words shift one stage per clock
    // Gray coding keeps a sampled word at most one count off
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stageQ[i] <= '0;
            end
        end else begin
            stageQ[0] <= dIn;
            for (int i = 1; i < STAGES; i++) begin
                stageQ[i] <= stageQ[i-1];
            end
        end
    end

    // delay is exactly STAGES cycles
    assign dOut = stageQ[STAGES-1];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the dual-clock bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_cdcStreamBridge \
    --Mdir obj_dir \
    -o simTb

output="$(./obj_dir/simTb)"
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

/* tests/cdcFifo_properties.sv */
// concurrent assertions on writes into a full FIFO and on Gray pointer steps, bound into cdcFifo
`default_nettype none

`include "cdcFifo_consts.svh"

module cdcFifo_properties
    import cdcFifoPkg::*;
(
    input logic w_clk,
    input logic r_clk,
    input logic rst,
    input logic writeEn,
    input ptr_t wrGrayLocal,
    input ptr_t rdGraySync,
    input ptr_t wrGray,
    input ptr_t rdGray
);

    // Gray to binary, each bit folds in all bits above it
    function automatic ptr_t grayToBin(input ptr_t grayVal);
        ptr_t binVal;
        binVal[`CDC_ADDR_WIDTH] = grayVal[`CDC_ADDR_WIDTH];
        for (int i = `CDC_ADDR_WIDTH - 1; i >= 0; i--) begin
            binVal[i] = binVal[i+1] ^ grayVal[i];
        end
        return binVal;
    endfunction

    // words stored as the writer sees them, modulo the wrap-extended range
    function automatic ptr_t writerFill(input ptr_t wrG, input ptr_t rdG);
        ptr_t fill;
        fill = grayToBin(wrG) - grayToBin(rdG);
        return fill;
    endfunction

    // a memory write needs a free entry against the synchronized read pointer
    noWriteWhileFull: assert property (
        @(posedge w_clk) disable iff (rst)
            writeEn |-> (writerFill(wrGrayLocal, rdGraySync) < `CDC_DEPTH)
    ) else $error("memory written while the FIFO holds a full set of words");

    // launched write pointer moves one Gray step at most per w_clk
    wrGrayOneBit: assert property (
        @(posedge w_clk) disable iff (rst) $countones(wrGray ^ $past(wrGray)) <= 1
    ) else $error("write Gray pointer changed more than one bit");

    // same for the read pointer in its own domain
    rdGrayOneBit: assert property (
        @(posedge r_clk) disable iff (rst) $countones(rdGray ^ $past(rdGray)) <= 1
    ) else $error("read Gray pointer changed more than one bit");

endmodule

// launch registers carry the registered Gray images that cross domains
// the local write pointer and the read pointer seen in w_clk give the writer's fill
bind cdcFifo cdcFifo_properties uProps (
    .w_clk       (w_clk),
    .r_clk       (r_clk),
    .rst         (rst),
    .writeEn     (writeEn),
    .wrGrayLocal (wrPtr.grayPtr),
    .rdGraySync  (rdGraySync),
    .wrGray      (wrGrayLaunch),
    .rdGray      (rdGrayLaunch)
);

`default_nettype wire

/* tests/tb_cdcStreamBridge.sv */
// testbench for the dual-clock stream bridge with clocks, stimulus, queue model and checks
`default_nettype none

`include "cdcFifo_consts.svh"

module tb_cdcStreamBridge
    import cdcFifoPkg::*;
();

    // cycles without progress before a wait gives up
    localparam int WAIT_LIMIT = 2000;

    logic  w_clk;
    logic  r_clk;
    logic  rst;
    logic  dInAck;
    data_t dIn;
    logic  dInReq;
    logic  dOutReq;
    logic  dOutAck;
    data_t dOut;

    // reference model, words in write order
    data_t modelQ [$];
    data_t expectedWord;
    int    valueErrors = 0;
    int    otherErrors = 0;
    int    writesSeen = 0;

    cdcStreamBridge i_dut (
        .w_clk   (w_clk),
        .rst     (rst),
        .dInAck  (dInAck),
        .dIn     (dIn),
        .dInReq  (dInReq),
        .r_clk   (r_clk),
        .dOutReq (dOutReq),
        .dOutAck (dOutAck),
        .dOut    (dOut)
    );

    // write clock, period 10
    initial begin
        w_clk = 1'b0;
        forever #5 w_clk = ~w_clk;
    end

    // read clock, period 14, so edges drift against w_clk
    initial begin
        r_clk = 1'b0;
        forever #7 r_clk = ~r_clk;
    end

    // oldest word still in the model is the one the next read must return
    function automatic data_t expectedHead(input data_t q [$]);
        return q[0];
    endfunction

    // record every push the bridge accepts
    always @(posedge w_clk) begin
        if (!rst && dInAck && dInReq) begin
            modelQ.push_back(dIn);
            writesSeen++;
        end
    end

    // compare each accepted read with the model, dOut must be zero otherwise
    always @(posedge r_clk) begin
        if (!rst && dOutReq && dOutAck) begin
            if (modelQ.size() == 0) begin
                otherErrors++;
                $display("a read was accepted while the reference queue was empty");
            end else begin
                expectedWord = expectedHead(modelQ);
                if (dOut !== expectedWord) begin
                    valueErrors++;
                    $display("error: dOut expected %h actual %h", expectedWord, dOut);
                end
                void'(modelQ.pop_front());
            end
        end else if (!rst && dOut !== '0) begin
            valueErrors++;
            $display("error: dOut expected %h actual %h", 8'h00, dOut);
        end
    end

    // producer, strobes at rate percent and holds a word until it is taken
    task automatic pushWords(input int count, input int rate, input bit randomData,
                             input data_t firstWord);
        int    accepted;
        int    waitCycles;
        data_t word;
        accepted = 0;
        waitCycles = 0;
        word = randomData ? data_t'($urandom) : firstWord;
        while (accepted < count && waitCycles < WAIT_LIMIT) begin
            @(posedge w_clk);
            if (dInAck && dInReq) begin
                accepted++;
                waitCycles = 0;
                word = randomData ? data_t'($urandom) : firstWord + data_t'(accepted);
            end else begin
                waitCycles++;
            end
            if (accepted < count && ($urandom % 100) < rate) begin
                dInAck <= 1'b1;
                dIn    <= word;
            end else begin
                dInAck <= 1'b0;
            end
        end
        if (accepted < count) begin
            otherErrors++;
            dInAck <= 1'b0;
            $display("timed out waiting for the bridge to accept a word");
        end
    endtask

    // consumer, strobes take at rate percent until count reads landed
    task automatic takeWords(input int count, input int rate);
        int taken;
        int waitCycles;
        taken = 0;
        waitCycles = 0;
        while (taken < count && waitCycles < WAIT_LIMIT) begin
            @(posedge r_clk);
            if (dOutReq && dOutAck) begin
                taken++;
                waitCycles = 0;
            end else begin
                waitCycles++;
            end
            if (taken < count && ($urandom % 100) < rate) begin
                dOutReq <= 1'b1;
            end else begin
                dOutReq <= 1'b0;
            end
        end
        if (taken < count) begin
            otherErrors++;
            dOutReq <= 1'b0;
            $display("timed out waiting for a word to read");
        end
    endtask

    // keeps pushing one more word against a full FIFO
    task automatic strobeWhileFull(input int cycles, input data_t word);
        repeat (cycles) begin
            @(posedge w_clk);
            if (dInReq !== 1'b0) begin
                valueErrors++;
                $display("error: dInReq expected %h actual %h", 1'b0, dInReq);
            end
            dInAck <= 1'b1;
            dIn    <= word;
        end
        @(posedge w_clk);
        dInAck <= 1'b0;
    endtask

    // empty flag has to hold low with nothing written
    task automatic checkEmptyHolds(input int cycles);
        repeat (cycles) begin
            @(posedge r_clk);
            if (dOutAck !== 1'b0) begin
                valueErrors++;
                $display("error: dOutAck expected %h actual %h", 1'b0, dOutAck);
            end
        end
    endtask

    // freed space reaches the writer through the read pointer sync
    task automatic waitForSpace();
        int waitCycles;
        waitCycles = 0;
        while (!dInReq && waitCycles < WAIT_LIMIT) begin
            @(posedge w_clk);
            waitCycles++;
        end
        if (!dInReq) begin
            otherErrors++;
            $display("timed out waiting for free space after the drain");
        end
    endtask

    task automatic waitForDrain();
        int waitCycles;
        waitCycles = 0;
        while (modelQ.size() != 0 && waitCycles < WAIT_LIMIT) begin
            @(posedge r_clk);
            waitCycles++;
        end
        if (modelQ.size() != 0) begin
            otherErrors++;
            $display("timed out with %0d words never read", modelQ.size());
        end
    endtask

    initial begin
        void'($urandom(32'h6a463881));
        rst     = 1'b1;
        dInAck  = 1'b0;
        dIn     = '0;
        dOutReq = 1'b0;
        repeat (2) @(posedge w_clk);
        rst <= 1'b0;

        // out of reset, room to write and nothing to read
        @(posedge w_clk);
        if (dInReq !== 1'b1) begin
            valueErrors++;
            $display("error: dInReq expected %h actual %h", 1'b1, dInReq);
        end
        @(posedge r_clk);
        if (dOutAck !== 1'b0) begin
            valueErrors++;
            $display("error: dOutAck expected %h actual %h", 1'b0, dOutAck);
        end

        // fill with the reader idle, then one push too many
        pushWords(`CDC_DEPTH, 100, 1'b0, 8'hA0);
        strobeWhileFull(10, 8'hEE);
        if (writesSeen != `CDC_DEPTH) begin
            otherErrors++;
            $display("the bridge took %0d words into a FIFO of 16", writesSeen);
        end

        // drain in order, then the FIFO has to stay empty
        takeWords(`CDC_DEPTH, 100);
        checkEmptyHolds(8);
        waitForSpace();

        // random rates on both sides, five segments of 100 words
        fork
            begin
                for (int seg = 0; seg < 5; seg++) begin
                    pushWords(100, 10 + int'($urandom % 90), 1'b1, 8'h00);
                end
            end
            begin
                for (int seg = 0; seg < 5; seg++) begin
                    takeWords(100, 10 + int'($urandom % 90));
                end
            end
        join
        waitForDrain();
        // every modelled word is read, so the bridge must hold none
        checkEmptyHolds(8);

        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
